//--- project.f
+incdir+include
source/decode_pkg.sv
source/opcode_classify.sv
source/field_check.sv
source/imm_gen.sv
source/control_gen.sv
source/rv32_decoder.sv
sim/tb_clock.sv
sim/tb_decoder.sv

//--- run.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_decoder -Mdir obj_dir -o tb_decoder
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_decoder > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

//--- sim/tb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module tb_decoder
    import decode_pkg::*;
();

    localparam int NUM_INSTR      = 2000;
    localparam int TIMEOUT_CYCLES = NUM_INSTR + NUM_INSTR / 10;  // Reset plus margin

    localparam logic [6:0] VALID_OPC [10] = '{`OPC_OP, `OPC_OPIMM, `OPC_LOAD, `OPC_STORE,
        `OPC_BRANCH, `OPC_JAL, `OPC_JALR, `OPC_LUI, `OPC_AUIPC, `OPC_FENCE};

    logic             clk;
    logic             rst_n;
    logic             advance;
    instr_word_u      instr;
    ctrl_word_t       ctrl;
    logic [`XLEN-1:0] imm;
    logic             fault;

    logic [31:0]      lfsr_state;
    ctrl_word_t       exp_ctrl;
    logic [`XLEN-1:0] exp_imm;
    logic             exp_imm_known;
    logic             exp_fault;
    logic [`XLEN-1:0] exp_word;
    int               checks;
    int               reset_errors;
    int               fault_errors;
    int               ctrl_errors;
    int               imm_errors;
    int               cycle_count;

    tb_clock u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv32_decoder u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .instr   (instr),
        .ctrl    (ctrl),
        .imm     (imm),
        .fault   (fault)
    );

    // Galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'ha300_0000;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] low;
        logic [31:0] sel;
        low = take_bits(4);
        sel = take_bits(3);
        return {(sel == 32'd0), low[3:0]};  // x16..x31 one time in 8
    endfunction

    task automatic make_instr(output logic [31:0] w);
        logic [31:0] r;
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [4:0]  rd;
        logic [2:0]  f3;
        r = take_bits(3);
        if (r != 32'd0) begin
            r   = take_bits(4) % 32'd10;
            opc = VALID_OPC[r[3:0]];
        end else begin
            r   = take_bits(7);
            opc = r[6:0];
        end
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        r   = take_bits(3);
        f3  = r[2:0];
        r   = take_bits(2);
        case (r[1:0])
            2'd0: f7 = 7'h00;
            2'd1: f7 = 7'h20;
            default: begin
                r  = take_bits(7);
                f7 = r[6:0];
            end
        endcase
        if (opc == `OPC_FENCE) begin
            r = take_bits(1);
            if (r[0]) begin
                {f7, rs2, rs1, rd} = '0;  // Gives legal FENCE words a fair chance
            end
        end
        w = {f7, rs2, rs1, f3, rd, opc};
    endtask

    task automatic decode_model(input logic [31:0] w, output ctrl_word_t c,
                                output logic [31:0] im, output logic im_known,
                                output logic flt);
        logic [6:0] f7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] f3;
        logic [4:0] rd;
        logic       rd_w;
        logic       rs1_r;
        logic       rs2_r;
        logic       alu_on;
        logic       mem_on;
        logic       bad;
        {f7, rs2, rs1, f3, rd} = w[31:7];
        {rd_w, rs1_r, rs2_r, alu_on, mem_on, bad} = 6'b0;
        c           = '0;
        c.alu_a_sel = ALU_A_RS1;
        c.alu_b_sel = ALU_B_IMM;
        c.wb_sel    = WB_ALU;
        c.pc_sel    = PC_NPC;
        im          = {{20{w[31]}}, w[31:20]};  // I-format
        im_known    = 1'b1;
        case (w[6:0])
            `OPC_OP: begin
                {rd_w, rs1_r, rs2_r, alu_on} = 4'b1111;
                c.alu.funct3 = f3;
                c.alu_b_sel  = ALU_B_RS2;
                c.alu.alt    = f7[5] & ((f3 == 3'd0) | (f3 == 3'd5));
                bad = f7[6] | (f7[4:0] != 5'd0) | (f7[5] & (f3 != 3'd0) & (f3 != 3'd5));
            end
            `OPC_OPIMM: begin
                {rd_w, rs1_r, alu_on} = 3'b111;
                c.alu.funct3 = f3;
                c.alu.alt    = f7[5] & (f3 == 3'd5);
                bad = ((f3 == 3'd1) & (f7 != 7'd0)) |
                      ((f3 == 3'd5) & (f7[6] | (f7[4:0] != 5'd0)));
            end
            `OPC_LOAD: begin
                {rd_w, rs1_r, alu_on, mem_on} = 4'b1111;
                c.wb_sel = WB_MEM;
                bad = (f3 == 3'd3) | (f3 == 3'd6) | (f3 == 3'd7);
            end
            `OPC_STORE: begin
                {rs1_r, rs2_r, alu_on, mem_on} = 4'b1111;
                c.mem.is_store = 1'b1;
                im  = {{20{w[31]}}, w[31:25], w[11:7]};
                bad = (f3 >= 3'd3);
            end
            `OPC_BRANCH: begin
                {rs1_r, rs2_r, alu_on} = 3'b111;
                c.alu.is_branch = 1'b1;
                c.alu.funct3    = f3;
                c.alu_b_sel     = ALU_B_RS2;
                c.pc_sel        = PC_BRANCH;
                im  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                bad = (f3 == 3'd2) | (f3 == 3'd3);
            end
            `OPC_JAL: begin
                rd_w     = 1'b1;
                c.wb_sel = WB_NPC;
                c.pc_sel = PC_JAL;
                im = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            `OPC_JALR: begin
                {rd_w, rs1_r, alu_on} = 3'b111;
                c.wb_sel = WB_NPC;
                c.pc_sel = PC_JALR;
                bad = (f3 != 3'd0);
            end
            `OPC_LUI: begin
                rd_w     = 1'b1;
                c.wb_sel = WB_IMM;
                im       = {w[31:12], 12'd0};
            end
            `OPC_AUIPC: begin
                {rd_w, alu_on} = 2'b11;
                c.alu_a_sel    = ALU_A_PC;
                im             = {w[31:12], 12'd0};
            end
            `OPC_FENCE: begin
                bad = (f3 >= 3'd2) | (rs1 != 5'd0) | (rd != 5'd0) | (f7[6:3] != 4'd0) |
                      ((f3 == 3'd1) & ((rs2 != 5'd0) | (f7[2:0] != 3'd0)));
            end
            default: begin
                bad      = 1'b1;
                im_known = 1'b0;  // No immediate format for unknown opcodes
            end
        endcase
        bad = bad | (rs1_r & rs1[4]) | (rs2_r & rs2[4]) | (rd_w & rd[4]);
        c.rf_read.en  = rs1_r & ~bad;
        c.rf_read.rs1 = rs1[3:0];
        c.rf_read.rs2 = rs2[3:0];
        c.alu.en      = alu_on & ~bad;
        c.mem.en      = mem_on & ~bad;
        c.mem.funct3  = f3;
        c.rf_write.en = rd_w & ~bad;
        c.rf_write.rd = rd[3:0];
        flt           = bad;
    endtask

    task automatic check_reset_state();
        logic [3:0] en;
        en = {ctrl.rf_read.en, ctrl.alu.en, ctrl.mem.en, ctrl.rf_write.en};
        if (fault !== 1'b0) begin
            $display("[ERROR] reset fault: expected 0, actual %0b", fault);
            reset_errors++;
        end
        if (en !== 4'b0000) begin
            $display("[ERROR] reset enables: expected 0000, actual %b", en);
            reset_errors++;
        end
        checks++;
    endtask

    task automatic compare_outputs(input string name);
        if (fault !== exp_fault) begin
            $display("[ERROR] %s fault: expected %0b, actual %0b (instr %h)",
                     name, exp_fault, fault, exp_word);
            fault_errors++;
        end
        if (ctrl !== exp_ctrl) begin
            $display("[ERROR] %s ctrl: expected %h, actual %h (instr %h)",
                     name, exp_ctrl, ctrl, exp_word);
            ctrl_errors++;
        end
        if (exp_imm_known && (imm !== exp_imm)) begin
            $display("[ERROR] %s imm: expected %h, actual %h (instr %h)",
                     name, exp_imm, imm, exp_word);
            imm_errors++;
        end
        checks++;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [31:0] word;
        logic [31:0] r;
        logic        sampled_adv;
        lfsr_state    = 32'hf1f1027c;
        advance       = 1'b0;
        instr         = '0;
        exp_ctrl      = '0;
        exp_imm       = '0;
        exp_imm_known = 1'b1;
        exp_fault     = 1'b0;
        exp_word      = '0;
        checks        = 0;
        reset_errors  = 0;
        fault_errors  = 0;
        ctrl_errors   = 0;
        imm_errors    = 0;

        @(negedge clk);
        while (rst_n !== 1'b1) begin
            check_reset_state();
            @(negedge clk);
        end
        check_reset_state();  // First cycle out of reset

        for (int n = 0; n < NUM_INSTR; n++) begin
            @(posedge clk);
            sampled_adv = advance;  // What the DUT takes at this edge
            if (advance) begin
                decode_model(instr, exp_ctrl, exp_imm, exp_imm_known, exp_fault);
                exp_word = instr;
            end
            make_instr(word);
            r = take_bits(2);
            advance <= (r[1:0] != 2'b00);  // High three cycles in four
            instr   <= word;
            @(negedge clk);
            if (sampled_adv) begin
                compare_outputs("decode");
            end else begin
                compare_outputs("hold");
            end
        end

        $display("Error counts: reset %0d, fault %0d, ctrl %0d, imm %0d in %0d checks",
                 reset_errors, fault_errors, ctrl_errors, imm_errors, checks);
        if (reset_errors + fault_errors + ctrl_errors + imm_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 10;  // 20 ns clock
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- source/rv32_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module rv32_decoder
    import decode_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              advance,
    input  instr_word_u       instr,
    output ctrl_word_t        ctrl,
    output logic [`XLEN-1:0]  imm,
    output logic              fault
);

    opc_class_t cls;
    logic       bad_opcode;
    logic       invalid;

    opcode_classify u_classify (
        .instr      (instr),
        .cls        (cls),
        .bad_opcode (bad_opcode)
    );

    field_check u_check (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance    (advance),
        .instr      (instr),
        .cls        (cls),
        .bad_opcode (bad_opcode),
        .invalid    (invalid),
        .fault      (fault)
    );

    // Enables are squashed here for faulting words
    control_gen u_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .instr   (instr),
        .cls     (cls),
        .invalid (invalid),
        .ctrl    (ctrl)
    );

    imm_gen u_imm (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .instr   (instr),
        .cls     (cls),
        .imm     (imm)
    );

endmodule

`default_nettype wire

//--- source/control_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module control_gen
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        advance,
    input  instr_word_u instr,
    input  opc_class_t  cls,
    input  logic        invalid,
    output ctrl_word_t  ctrl
);

    ctrl_word_t           ctrl_next;
    logic [`FUNCT3_W-1:0] funct3;
    logic                 alu_uses_funct3;
    logic                 shift_right;

    assign funct3          = instr.r.funct3;
    assign alu_uses_funct3 = cls.op | cls.opimm | cls.branch;
    assign shift_right     = funct3 == 3'd5;

    always_comb begin
        // Read stage
        ctrl_next.rf_read.en  = ~invalid & (cls.op | cls.opimm | cls.load | cls.store |
                                            cls.branch | cls.jalr);
        ctrl_next.rf_read.rs1 = instr.r.rs1[`REG_IDX_W-1:0];
        ctrl_next.rf_read.rs2 = instr.r.rs2[`REG_IDX_W-1:0];

        // Execute stage, address math for LOAD/STORE/JALR uses ADD
        ctrl_next.alu.en        = ~invalid & (cls.op | cls.opimm | cls.branch | cls.load |
                                              cls.store | cls.auipc | cls.jalr);
        ctrl_next.alu.is_branch = cls.branch;
        ctrl_next.alu.alt       = instr.r.funct7[5] &
                                  ((cls.op & ((funct3 == 3'd0) | shift_right)) |
                                   (cls.opimm & shift_right));
        ctrl_next.alu.funct3    = alu_uses_funct3 ? funct3 : 3'd0;

        // Memory stage
        ctrl_next.mem.en       = ~invalid & (cls.load | cls.store);
        ctrl_next.mem.is_store = cls.store;
        ctrl_next.mem.funct3   = funct3;

        // Write back stage
        ctrl_next.rf_write.en = ~invalid & (cls.op | cls.opimm | cls.load | cls.jal |
                                            cls.jalr | cls.lui | cls.auipc);
        ctrl_next.rf_write.rd = instr.r.rd[`REG_IDX_W-1:0];

        ctrl_next.alu_a_sel = cls.auipc ? ALU_A_PC : ALU_A_RS1;
        ctrl_next.alu_b_sel = (cls.op | cls.branch) ? ALU_B_RS2 : ALU_B_IMM;

        if (cls.lui) begin
            ctrl_next.wb_sel = WB_IMM;
        end else if (cls.load) begin
            ctrl_next.wb_sel = WB_MEM;
        end else if (cls.jal | cls.jalr) begin
            ctrl_next.wb_sel = WB_NPC;  // Link address
        end else begin
            ctrl_next.wb_sel = WB_ALU;
        end

        if (cls.jalr) begin
            ctrl_next.pc_sel = PC_JALR;
        end else if (cls.jal) begin
            ctrl_next.pc_sel = PC_JAL;
        end else if (cls.branch) begin
            ctrl_next.pc_sel = PC_BRANCH;
        end else begin
            ctrl_next.pc_sel = PC_NPC;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else if (advance) begin
            ctrl <= ctrl_next;
        end
    end

endmodule

`default_nettype wire

//--- source/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module imm_gen
    import decode_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              advance,
    input  instr_word_u       instr,
    input  opc_class_t        cls,
    output logic [`XLEN-1:0]  imm
);

    logic [`XLEN-1:0] imm_next;
    logic             sign;

    assign sign = instr.r.funct7[6];  // Instruction bit 31 in every format

    always_comb begin
        if (cls.store) begin
            imm_next = {{20{sign}}, instr.s.imm_11_5, instr.s.imm_4_0};
        end else if (cls.branch) begin
            imm_next = {{19{sign}}, instr.b.imm_12, instr.b.imm_11,
                        instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
        end else if (cls.lui | cls.auipc) begin
            imm_next = {instr.u.imm_31_12, 12'd0};
        end else if (cls.jal) begin
            imm_next = {{11{sign}}, instr.j.imm_20, instr.j.imm_19_12,
                        instr.j.imm_11, instr.j.imm_10_1, 1'b0};
        end else begin
            // JALR, LOAD, OP-IMM, OP, FENCE and unknown opcodes
            imm_next = {{20{sign}}, instr.i.imm_11_0};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            imm <= '0;
        end else if (advance) begin
            imm <= imm_next;
        end
    end

endmodule

`default_nettype wire

//--- source/field_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module field_check
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        advance,
    input  instr_word_u instr,
    input  opc_class_t  cls,
    input  logic        bad_opcode,
    output logic        invalid,
    output logic        fault
);

    logic [`REG_IDX_W:0]  rd;
    logic [`REG_IDX_W:0]  rs1;
    logic [`REG_IDX_W:0]  rs2;
    logic [`FUNCT3_W-1:0] funct3;
    logic [`FUNCT7_W-1:0] funct7;
    logic                 reads_rs1;
    logic                 reads_rs2;
    logic                 writes_rd;
    logic                 f7_other_bits;
    logic                 bad_reg;
    logic                 bad_funct3;
    logic                 bad_funct7;
    logic                 bad_fence;

    assign rd     = instr.r.rd;
    assign rs1    = instr.r.rs1;
    assign rs2    = instr.r.rs2;
    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;

    assign reads_rs1 = cls.op | cls.opimm | cls.load | cls.store | cls.branch | cls.jalr;
    assign reads_rs2 = cls.op | cls.store | cls.branch;
    assign writes_rd = cls.op | cls.opimm | cls.load | cls.jal | cls.jalr | cls.lui | cls.auipc;

    // Index bit 4 names x16..x31, absent in RV32E
    assign bad_reg = (reads_rs1 & rs1[`REG_IDX_W]) |
                     (reads_rs2 & rs2[`REG_IDX_W]) |
                     (writes_rd & rd[`REG_IDX_W]);

    assign bad_funct3 = (cls.store & (funct3 >= 3'd3)) |
                        (cls.load & ((funct3 == 3'd3) | (funct3[2:1] == 2'b11))) |
                        (cls.jalr & (funct3 != 3'd0)) |
                        (cls.branch & (funct3[2:1] == 2'b01)) |
                        (cls.fence & (funct3[2:1] != 2'b00));

    assign f7_other_bits = funct7[6] | (funct7[4:0] != 5'd0);  // Anything but bit 5

    assign bad_funct7 =
        (cls.op & f7_other_bits) |
        (cls.op & funct7[5] & (funct3 != 3'd0) & (funct3 != 3'd5)) |
        (cls.opimm & (funct3 == 3'd1) & (funct7 != 7'd0)) |
        (cls.opimm & (funct3 == 3'd5) & f7_other_bits);

    // FENCE.I also needs rs2 and the low funct7 bits clear
    assign bad_fence = cls.fence & ((rs1 != '0) | (rd != '0) | (funct7[6:3] != 4'd0) |
                       (funct3[0] & ((rs2 != '0) | (funct7[2:0] != 3'd0))));

    assign invalid = bad_opcode | bad_reg | bad_funct3 | bad_funct7 | bad_fence;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault <= 1'b0;
        end else if (advance) begin
            fault <= invalid;
        end
    end

endmodule

`default_nettype wire

//--- source/opcode_classify.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module opcode_classify
    import decode_pkg::*;
(
    input  instr_word_u instr,
    output opc_class_t  cls,
    output logic        bad_opcode
);

    always_comb begin
        cls        = '0;
        bad_opcode = 1'b0;
        case (instr.r.opcode)
            `OPC_OP: begin
                cls.op = 1'b1;
            end
            `OPC_OPIMM: begin
                cls.opimm = 1'b1;
            end
            `OPC_LOAD: begin
                cls.load = 1'b1;
            end
            `OPC_STORE: begin
                cls.store = 1'b1;
            end
            `OPC_BRANCH: begin
                cls.branch = 1'b1;
            end
            `OPC_JAL: begin
                cls.jal = 1'b1;
            end
            `OPC_JALR: begin
                cls.jalr = 1'b1;
            end
            `OPC_LUI: begin
                cls.lui = 1'b1;
            end
            `OPC_AUIPC: begin
                cls.auipc = 1'b1;
            end
            `OPC_FENCE: begin
                cls.fence = 1'b1;
            end
            default: begin
                bad_opcode = 1'b1;  // SYSTEM and compressed encodings land here
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/decode_pkg.sv
`default_nettype none

`include "decode_settings.svh"

package decode_pkg;

    // Instruction word views, register fields keep the full 5 bits
    typedef struct packed {
        logic [`FUNCT7_W-1:0]  funct7;
        logic [`REG_IDX_W:0]   rs2;
        logic [`REG_IDX_W:0]   rs1;
        logic [`FUNCT3_W-1:0]  funct3;
        logic [`REG_IDX_W:0]   rd;
        logic [`OPCODE_W-1:0]  opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [`REG_IDX_W:0]   rs1;
        logic [`FUNCT3_W-1:0]  funct3;
        logic [`REG_IDX_W:0]   rd;
        logic [`OPCODE_W-1:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [`REG_IDX_W:0]   rs2;
        logic [`REG_IDX_W:0]   rs1;
        logic [`FUNCT3_W-1:0]  funct3;
        logic [4:0]            imm_4_0;
        logic [`OPCODE_W-1:0]  opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [`REG_IDX_W:0]   rs2;
        logic [`REG_IDX_W:0]   rs1;
        logic [`FUNCT3_W-1:0]  funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [`OPCODE_W-1:0]  opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [`REG_IDX_W:0]   rd;
        logic [`OPCODE_W-1:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [`REG_IDX_W:0]   rd;
        logic [`OPCODE_W-1:0]  opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_word_u;

    // One-hot when the opcode is valid, all zero otherwise
    typedef struct packed {
        logic op;
        logic opimm;
        logic load;
        logic store;
        logic branch;
        logic jal;
        logic jalr;
        logic lui;
        logic auipc;
        logic fence;
    } opc_class_t;

    typedef struct packed {
        logic                  en;
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
    } rf_read_t;

    typedef struct packed {
        logic                  en;
        logic                  is_branch;
        logic                  alt;     // SUB / SRA / SRAI
        logic [`FUNCT3_W-1:0]  funct3;
    } alu_op_t;

    typedef struct packed {
        logic                  en;
        logic                  is_store;
        logic [`FUNCT3_W-1:0]  funct3;  // Access size and sign
    } mem_op_t;

    typedef struct packed {
        logic                  en;
        logic [`REG_IDX_W-1:0] rd;
    } rf_write_t;

    typedef enum logic {ALU_A_RS1 = 1'b0, ALU_A_PC = 1'b1} alu_a_sel_e;
    typedef enum logic {ALU_B_RS2 = 1'b0, ALU_B_IMM = 1'b1} alu_b_sel_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_IMM = 2'd1,
        WB_MEM = 2'd2,
        WB_NPC = 2'd3
    } wb_sel_e;

    typedef enum logic [1:0] {
        PC_NPC    = 2'd0,
        PC_JALR   = 2'd1,  // rs1 + imm with bit 0 cleared
        PC_JAL    = 2'd2,
        PC_BRANCH = 2'd3   // pc + imm when taken
    } pc_sel_e;

    typedef struct packed {
        rf_read_t   rf_read;
        alu_op_t    alu;
        mem_op_t    mem;
        rf_write_t  rf_write;
        alu_a_sel_e alu_a_sel;
        alu_b_sel_e alu_b_sel;
        wb_sel_e    wb_sel;
        pc_sel_e    pc_sel;
    } ctrl_word_t;

endpackage

`default_nettype wire

//--- include/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Word and field widths
`define XLEN        32
`define REG_IDX_W   4   // RV32E keeps x0..x15
`define OPCODE_W    7
`define FUNCT3_W    3
`define FUNCT7_W    7

// Major opcodes of the kept groups
`define OPC_OP      7'b0110011
`define OPC_OPIMM   7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_FENCE   7'b0001111  // FENCE and FENCE.I

`endif
